// ==== dv/tm_gen_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module tm_gen_assert (
	input logic                        clk,
	input logic                        n_rst,
	input tm_sched_pkg::link_cfg_t     cfg,
	input tm_sched_pkg::timer_status_t status,
	input tm_sched_pkg::cadence_t      cadence,
	input logic                        tm_rdy,
	input logic                        sr_rdy,
	input logic                        pre_tm
);

	import tm_sched_pkg::*;

	// the telemetry flag only rises on the cycle after a telemetry strobe
	tm_rdy_rise: assert property (@(posedge clk) disable iff (!n_rst)
		$rose(tm_rdy) |-> $past(cadence.tm))
		else $error("tm_rdy rose without a telemetry strobe one cycle before");

	// the status request flag follows the period strobe in the same way
	sr_rdy_rise: assert property (@(posedge clk) disable iff (!n_rst)
		$rose(sr_rdy) |-> $past(status.period_end))
		else $error("sr_rdy rose without a period strobe one cycle before");

	// the window is masked by the strobe it announces
	pre_tm_vs_tm: assert property (@(posedge clk) disable iff (!n_rst)
		!(pre_tm && cadence.tm))
		else $error("pre_tm high together with the telemetry strobe");

	// the window is always closed on the wrap tick of a period
	wrap_no_pre_tm: assert property (@(posedge clk) disable iff (!n_rst)
		status.period_end |-> !pre_tm)
		else $error("pre_tm high on the wrap tick");

	// at 10 Hz every period carries telemetry, so the enable never drops
	fast_rate_en: assert property (@(posedge clk) disable iff (!n_rst)
		(cfg.tm_rate == tm_10hz) |-> cadence.pre_tm_en)
		else $error("pre_tm_en low at the 10 Hz telemetry rate");

endmodule

// bound to the top level, where the scheduler inputs and the configuration meet
bind tm_gen tm_gen_assert tm_gen_assert_i (
	.clk     (clk),
	.n_rst   (n_rst),
	.cfg     (cfg),
	.status  (status),
	.cadence (cadence),
	.tm_rdy  (tm_rdy),
	.sr_rdy  (sr_rdy),
	.pre_tm  (pre_tm)
);

`default_nettype wire

// ==== dv/tm_gen_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module tm_gen_tb;

	import tm_sched_pkg::*;

	// period length and the first window tick for each link rate
	localparam int period_len = 100_000;
	localparam int guard = 2;
	localparam int win_1m = period_len - 748 - 1 - guard;
	localparam int win_125k = period_len - 5984 - 1 - guard;
	localparam int rst_cycles = 16;

	// each run stops two cycles after a period end so the last rise is seen
	localparam int len_fast = 3 * period_len + 2;
	localparam int len_slow = 30 * period_len + 2;
	localparam int len_win = 2 * period_len + 2;
	localparam int len_bp = 5 * period_len + 2;
	localparam int len_rst = period_len + 2;
	localparam int total_cycles = len_fast + len_slow + 2 * len_win + len_bp + len_rst
		+ 6 * (rst_cycles + 2);

	// watchdog limit in ns is all test lengths at 8 ns plus a tenth
	localparam longint wd_ns = longint'(total_cycles) * 8 * 11 / 10;

	logic      clk;
	logic      n_rst;
	link_cfg_t cfg;
	logic      tm_ack;
	logic      sr_ack;
	logic      tm_rdy;
	logic      sr_rdy;
	logic      pre_tm;

	// lfsr state, model state and scoreboard
	logic [15:0] lfsr_state;
	int          m_ticks;
	int          m_periods;
	logic        m_tm_rdy;
	logic        m_sr_rdy;
	int          tm_wait;
	int          sr_wait;
	int          errors;
	int          tests_passed;
	int          tests_failed;

	tm_gen tm_gen_i (
		.clk    (clk),
		.n_rst  (n_rst),
		.cfg    (cfg),
		.tm_ack (tm_ack),
		.sr_ack (sr_ack),
		.tm_rdy (tm_rdy),
		.sr_rdy (sr_rdy),
		.pre_tm (pre_tm)
	);

	always #4 clk = ~clk;

	// 16 bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// the lfsr steps once for every bit that goes into val
	task automatic take_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[14:0], lfsr_state[0]};
		end
	endtask

	// compare one output with its predicted level
	// only the first ten mismatches of a test are printed but all are counted
	task automatic check_bit(input string test, input string sig, input logic exp,
		input logic act);
		if (act !== exp)
		begin
			errors++;
			if (errors <= 10)
				$display("Fail %s %s expected %0b actual %0b at tick %0d period %0d",
					test, sig, exp, act, m_ticks, m_periods);
		end
	endtask

	// acks for the coming edge
	// mode 1 acks each raised flag after a random delay of 0 to 15 cycles,
	// mode 2 withholds acks and then issues one late ack and one colliding ack
	task automatic drive_acks(input int mode);
		logic [15:0] r;
		tm_ack = 1'b0;
		sr_ack = 1'b0;
		if (mode == 1)
		begin
			if (m_tm_rdy && tm_wait < 0)
			begin
				take_bits(4, r);
				tm_wait = r;
			end
			if (m_sr_rdy && sr_wait < 0)
			begin
				take_bits(4, r);
				sr_wait = r;
			end
			if (tm_wait == 0)
				tm_ack = 1'b1;
			if (sr_wait == 0)
				sr_ack = 1'b1;
			if (tm_wait >= 0)
				tm_wait--;
			if (sr_wait >= 0)
				sr_wait--;
		end
		else if (mode == 2)
		begin
			// one ack in the middle of period 3 clears three absorbed events
			if (m_periods == 3 && m_ticks == period_len / 2)
			begin
				tm_ack = 1'b1;
				sr_ack = 1'b1;
			end
			// this ack lands on the strobe that ends period 4 and the strobe wins
			if (m_periods == 4 && m_ticks == period_len - 1)
			begin
				tm_ack = 1'b1;
				sr_ack = 1'b1;
			end
		end
	endtask

	// mode 3 lets one lfsr bit decide between random acks and no acks at all
	task automatic run_test(input string name, input link_rate_e lr, input tm_rate_e tr,
		input int n_cycles, input int ack_mode);
		logic [15:0] r;
		logic        period_end;
		logic        exp_en;
		logic        exp_tm;
		logic        exp_pre;
		int          win;
		int          mode;
		// the configuration is only applied while reset is held
		n_rst = 1'b0;
		cfg.link_rate = lr;
		cfg.tm_rate = tr;
		tm_ack = 1'b0;
		sr_ack = 1'b0;
		mode = ack_mode;
		if (ack_mode == 3)
		begin
			take_bits(1, r);
			mode = r[0] ? 1 : 0;
		end
		m_ticks = 0;
		m_periods = 0;
		m_tm_rdy = 1'b0;
		m_sr_rdy = 1'b0;
		tm_wait = -1;
		sr_wait = -1;
		errors = 0;
		win = (lr == link_125k) ? win_125k : win_1m;
		repeat (rst_cycles) @(posedge clk);
		#1;
		n_rst = 1'b1;
		for (int c = 0; c < n_cycles; c++)
		begin
			// predicted strobes and window for the current tick
			period_end = (m_ticks == period_len - 1);
			exp_en = (tr == tm_10hz) || (m_periods % 10 == 9);
			exp_tm = period_end && exp_en;
			exp_pre = exp_en && (m_ticks >= win) && !exp_tm;
			check_bit(name, "tm_rdy", m_tm_rdy, tm_rdy);
			check_bit(name, "sr_rdy", m_sr_rdy, sr_rdy);
			check_bit(name, "pre_tm", exp_pre, pre_tm);
			drive_acks(mode);
			// flag levels at the next edge where an event beats an ack
			if (exp_tm)
				m_tm_rdy = 1'b1;
			else if (tm_ack)
				m_tm_rdy = 1'b0;
			if (period_end)
				m_sr_rdy = 1'b1;
			else if (sr_ack)
				m_sr_rdy = 1'b0;
			if (period_end)
			begin
				m_ticks = 0;
				m_periods++;
			end
			else
			begin
				m_ticks++;
			end
			@(posedge clk);
			#1;
		end
		tm_ack = 1'b0;
		sr_ack = 1'b0;
		if (errors == 0)
		begin
			tests_passed++;
			$display("test %s finished, acks mode %0d, no mismatches", name, mode);
		end
		else
		begin
			tests_failed++;
			$display("test %s finished, acks mode %0d, %0d mismatches", name, mode, errors);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		n_rst = 1'b0;
		cfg = '0;
		tm_ack = 1'b0;
		sr_ack = 1'b0;
		lfsr_state = 16'd28858;
		tests_passed = 0;
		tests_failed = 0;
		run_test("fast_rate_acks", link_1m, tm_10hz, len_fast, 1);
		run_test("slow_rate", link_1m, tm_1hz, len_slow, 3);
		run_test("window_1m", link_1m, tm_10hz, len_win, 3);
		run_test("window_125k", link_125k, tm_10hz, len_win, 3);
		run_test("backpressure", link_1m, tm_10hz, len_bp, 2);
		run_test("reset", link_125k, tm_1hz, len_rst, 0);
		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// a hung run ends here
	initial
	begin
		#(wd_ns);
		$display("watchdog expired after %0d ns, the tests did not complete", wd_ns);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/tm_sched_pkg.sv
rtl/frame_timer.sv
rtl/tm_cadence.sv
rtl/tx_scheduler.sv
rtl/tm_gen.sv
dv/tm_gen_assert.sv
dv/tm_gen_tb.sv

// ==== rtl/frame_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_timer (
	input  logic                        clk,
	input  logic                        n_rst,
	output tm_sched_pkg::timer_status_t status
);

	import tm_sched_pkg::*;

	// last tick of the period, the count wraps to zero right after it
	localparam logic [ticks_w-1:0] last_tick = ticks_w'(period_ticks - 1);

	// tick position inside the current 100 ms period
	logic [ticks_w-1:0] ticks;

	// high for exactly one cycle, on the final tick of every period
	logic period_end;

	// the strobe is decoded straight from the count, so it lines up with
	// the tick value that the window compare in the scheduler sees
	assign period_end = (ticks == last_tick);

	// free running period counter
	// the first strobe comes 99 999 cycles after reset release, and from
	// then on once every 100 000 cycles
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			ticks <= '0;
		end
		else if (period_end)
		begin
			// wrap on the cycle after the strobe
			ticks <= '0;
		end
		else
		begin
			ticks <= ticks + 1'b1;
		end
	end

	// both the status request and the window position are taken from
	// this one count, so they can never drift apart
	assign status.period_end = period_end;
	assign status.ticks      = ticks;

endmodule

`default_nettype wire

// ==== rtl/tm_cadence.sv ====
`timescale 1ns/10ps
`default_nettype none

module tm_cadence (
	input  logic                   clk,
	input  logic                   n_rst,
	input  tm_sched_pkg::tm_rate_e tm_rate,
	input  logic                   period_end,
	output tm_sched_pkg::cadence_t cadence
);

	import tm_sched_pkg::*;

	// index of the last period in a slow telemetry cycle
	localparam logic [cadence_w-1:0] last_period_idx =
		cadence_w'(periods_per_tm_slow - 1);

	// period index within the current telemetry cycle, 0 to 9
	logic [cadence_w-1:0] period_idx;

	// high during the whole period that ends with a slow-rate telemetry
	logic last_period;

	// period strobe that also closes a telemetry cycle
	logic cycle_end;

	assign last_period = (period_idx == last_period_idx);
	assign cycle_end   = period_end & last_period;

	// the index advances once per period strobe and wraps after ten periods
	// it keeps counting at the fast rate as well, where it is simply unused,
	// since the rate only changes while the block is held in reset
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			period_idx <= '0;
		end
		else if (cycle_end)
		begin
			period_idx <= '0;
		end
		else if (period_end)
		begin
			period_idx <= period_idx + 1'b1;
		end
	end

	// telemetry strobe and window enable
	// at 10 Hz every period strobe is a telemetry strobe and the window
	// is enabled in every period
	// at 1 Hz only the strobe that closes the tenth period passes, and the
	// window enable covers that tenth period from its first tick to its last
	// so it falls again as soon as the index wraps
	always_comb
	begin
		if (tm_rate == tm_1hz)
		begin
			cadence.tm        = cycle_end;
			cadence.pre_tm_en = last_period;
		end
		else
		begin
			cadence.tm        = period_end;
			cadence.pre_tm_en = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tm_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tm_gen (
	input  logic                    clk,
	input  logic                    n_rst,
	input  tm_sched_pkg::link_cfg_t cfg,
	input  logic                    tm_ack,
	input  logic                    sr_ack,
	output logic                    tm_rdy,
	output logic                    sr_rdy,
	output logic                    pre_tm
);

	import tm_sched_pkg::*;

	// tick count and period strobe, shared by the divider and the scheduler
	timer_status_t status;

	// telemetry strobe and window enable from the divider
	cadence_t cadence;

	// 100 ms period counter, the time base of the whole schedule
	frame_timer frame_timer_i (
		.clk    (clk),
		.n_rst  (n_rst),
		.status (status)
	);

	// steps once per period strobe, so it always agrees with the timer
	// about where a telemetry cycle starts
	tm_cadence tm_cadence_i (
		.clk        (clk),
		.n_rst      (n_rst),
		.tm_rate    (cfg.tm_rate),
		.period_end (status.period_end),
		.cadence    (cadence)
	);

	// ready flags against the acks of the transmitter, and the
	// pre-telemetry window placed by the link rate
	tx_scheduler tx_scheduler_i (
		.clk       (clk),
		.n_rst     (n_rst),
		.link_rate (cfg.link_rate),
		.status    (status),
		.cadence   (cadence),
		.tm_ack    (tm_ack),
		.sr_ack    (sr_ack),
		.tm_rdy    (tm_rdy),
		.sr_rdy    (sr_rdy),
		.pre_tm    (pre_tm)
	);

endmodule

`default_nettype wire

// ==== rtl/tm_sched_pkg.sv ====
`default_nettype none

package tm_sched_pkg;

	// system clock of the scheduler, one tick per microsecond
	localparam int unsigned clk_freq_hz = 1_000_000;

	// one schedule period is 100 ms, the status request cadence of the link
	localparam int unsigned period_ticks = clk_freq_hz / 10;

	// wide enough to hold period_ticks - 1, which is 99 999 at 1 MHz
	localparam int unsigned ticks_w = $clog2(period_ticks);

	// a control word is 4 service, 62 data and 2 crc bytes
	localparam int unsigned ccw_bytes = 4 + 62 + 2;

	// each byte goes out as an 11 bit character on the serial line
	localparam int unsigned char_bits = 11;
	localparam int unsigned ccw_bits = ccw_bytes * char_bits;

	// control word time in clock ticks, 748 us at 1 Mbit/s
	localparam int unsigned ccw_ticks_1m = ccw_bits * (clk_freq_hz / 1_000_000);

	// the slow link is eight times longer per bit, so 5984 us
	localparam int unsigned ccw_ticks_125k = ccw_ticks_1m * 8;

	// the window opens two ticks early so the transmitter sees it in time
	localparam int unsigned pre_tm_guard = 2;

	// first tick of the pre-telemetry window for each link rate
	localparam logic [ticks_w-1:0] pre_tm_start_1m =
		ticks_w'(period_ticks - ccw_ticks_1m - 1 - pre_tm_guard);
	localparam logic [ticks_w-1:0] pre_tm_start_125k =
		ticks_w'(period_ticks - ccw_ticks_125k - 1 - pre_tm_guard);

	// at the 1 Hz telemetry rate only every tenth period carries telemetry
	localparam int unsigned periods_per_tm_slow = 10;
	localparam int unsigned cadence_w = 4;

	// serial link bit rate
	typedef enum logic {
		link_1m   = 1'b0,
		link_125k = 1'b1
	} link_rate_e;

	// telemetry rate, every period or every tenth period
	typedef enum logic {
		tm_10hz = 1'b0,
		tm_1hz  = 1'b1
	} tm_rate_e;

	// run-time configuration, only changed while n_rst is low
	typedef struct packed {
		link_rate_e link_rate;
		tm_rate_e   tm_rate;
	} link_cfg_t;

	// period_end is a one cycle strobe on the final tick of a period
	typedef struct packed {
		logic               period_end;
		logic [ticks_w-1:0] ticks;
	} timer_status_t;

	// tm is a one cycle strobe, pre_tm_en is a level covering the whole period
	typedef struct packed {
		logic tm;
		logic pre_tm_en;
	} cadence_t;

endpackage

`default_nettype wire

// ==== rtl/tx_scheduler.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_scheduler (
	input  logic                        clk,
	input  logic                        n_rst,
	input  tm_sched_pkg::link_rate_e    link_rate,
	input  tm_sched_pkg::timer_status_t status,
	input  tm_sched_pkg::cadence_t      cadence,
	input  logic                        tm_ack,
	input  logic                        sr_ack,
	output logic                        tm_rdy,
	output logic                        sr_rdy,
	output logic                        pre_tm
);

	import tm_sched_pkg::*;

	// next level of a ready flag
	// an event sets the flag and wins over an ack in the same cycle, so a
	// request that lands on top of the ack of the previous one is not lost
	// an ack only clears a flag that is already high, and with no event and
	// no ack the flag just holds
	function automatic logic flag_next(
		input logic cur,
		input logic evt,
		input logic ack
	);
		logic nxt;
		if (evt)
		begin
			nxt = 1'b1;
		end
		else if (ack)
		begin
			nxt = 1'b0;
		end
		else
		begin
			nxt = cur;
		end
		return nxt;
	endfunction

	// first tick of the pre-telemetry window for the current link rate
	logic [ticks_w-1:0] win_start;

	// tick count has reached the window start
	logic in_window;

	// next values of the two ready flags
	logic tm_rdy_next;
	logic sr_rdy_next;

	assign tm_rdy_next = flag_next(tm_rdy, cadence.tm, tm_ack);
	assign sr_rdy_next = flag_next(sr_rdy, status.period_end, sr_ack);

	// both flags rise one cycle after their strobe
	// there is no queue behind them, so events that arrive while a flag
	// is still waiting for its ack are absorbed into that flag
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			tm_rdy <= 1'b0;
			sr_rdy <= 1'b0;
		end
		else
		begin
			tm_rdy <= tm_rdy_next;
			sr_rdy <= sr_rdy_next;
		end
	end

	// the window has to fit one full control word before the end of the
	// period, so a slower link opens it earlier
	// 1 Mbit/s gives tick 99 249, 125 kbit/s gives tick 94 013
	always_comb
	begin
		if (link_rate == link_125k)
		begin
			win_start = pre_tm_start_125k;
		end
		else
		begin
			win_start = pre_tm_start_1m;
		end
	end

	assign in_window = (status.ticks >= win_start);

	// pre-telemetry level, purely combinational from the count
	// the enable restricts it to periods that end in telemetry, and the
	// telemetry strobe itself masks the final tick, so the window closes
	// at tick 99 998 and the transmitter sees tm_rdy without overlap
	assign pre_tm = cadence.pre_tm_en & in_window & ~cadence.tm;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the tm_gen testbench with Verilator and run it
# the run fails when the log holds the fail message or lacks the pass message

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tm_gen_tb -f project.f -o tm_gen_sim \
	|| { echo "verilator build failed"; exit 1; }

./obj_dir/tm_gen_sim > sim.log 2>&1
cat sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0
